/* Makefile */
TOP = tb_top

all: run

build:
	verilator --binary --timing -Wno-fatal -f all.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* all.f */
+incdir+design
design/msg_pkg.sv
design/pump_pkg.sv
design/block_store.sv
design/block_read_fsm.sv
design/beat_counter.sv
design/stream_fifo.sv
design/stream_pump_out.sv
design/mem_stream_top.sv
dv/stream_checker.sv
dv/tb_top.sv

/* design/beat_counter.sv */
// *******************************************************************
// beat counter
// loadable wrapping count of the current stream word
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "stream_defs.svh"

module beat_counter
(
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire                 set_i,
  input  wire                 en_i,
  input  wire pump_pkg::cnt_t val_i,
  output pump_pkg::cnt_t      count_o
);

  localparam pump_pkg::cnt_t max_lp = pump_pkg::cnt_t'(`STREAM_WORDS - 1);

  // set has priority over the step, and both wait for enable
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      count_o <= '0;
    else if (en_i)
    begin
      if (set_i)
        count_o <= val_i;
      else if (count_o == max_lp)
        count_o <= '0;
      else
        count_o <= count_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/block_read_fsm.sv */
// *******************************************************************
// block read FSM
// takes one request, reads its words and offers them to the pump
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "stream_defs.svh"

module block_read_fsm
(
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire                     req_v_i,
  input  wire msg_pkg::msg_type_e req_type_i,
  input  wire msg_pkg::addr_t     req_addr_i,
  input  wire msg_pkg::size_t     req_size_i,
  output logic                    req_ready_o,
  output logic                    rd_v_o,
  output msg_pkg::word_idx_t      rd_idx_o,
  input  wire msg_pkg::data_t     rd_data_i,
  output logic                    fsm_v_o,
  output msg_pkg::msg_type_e      fsm_type_o,
  output msg_pkg::addr_t          fsm_addr_o,
  output msg_pkg::size_t          fsm_size_o,
  output msg_pkg::data_t          fsm_data_o,
  input  wire                     fsm_ready_and_i
);

  localparam logic [3:0] fsm_mask_lp = `STREAM_FSM_MASK;

  pump_pkg::rd_state_e state_r, state_n;
  msg_pkg::msg_type_e type_r;
  msg_pkg::addr_t addr_r;
  msg_pkg::size_t size_r;
  msg_pkg::data_t data_r;
  msg_pkg::word_idx_t idx_base;
  pump_pkg::cnt_t beat_r, first_cnt, span, need_last, word_cnt;
  logic accept, beat_done, last_beat;

  assign accept = req_v_i & req_ready_o;
  assign beat_done = fsm_v_o & fsm_ready_and_i;

  // types outside the producer mask fetch only the critical word
  assign first_cnt = addr_r[`STREAM_OFFSET_W +: `STREAM_CNT_W];
  assign span = pump_pkg::last_offset(size_r);
  assign need_last = fsm_mask_lp[type_r] ? span : '0;
  assign last_beat = (beat_r == need_last);
  assign word_cnt = pump_pkg::wrap_cnt(first_cnt, first_cnt + beat_r, span);

  // upper index bits come straight from the address
  assign idx_base = msg_pkg::word_idx_t'(addr_r[`STREAM_ADDR_W-1:`STREAM_OFFSET_W]);
  assign rd_idx_o = {idx_base[$bits(msg_pkg::word_idx_t)-1:`STREAM_CNT_W], word_cnt};

  assign req_ready_o = (state_r == pump_pkg::e_idle);
  assign rd_v_o = (state_r == pump_pkg::e_issue);
  assign fsm_v_o = (state_r == pump_pkg::e_done);

  // header is held for the whole transaction, as the pump expects
  assign fsm_type_o = type_r;
  assign fsm_addr_o = addr_r;
  assign fsm_size_o = size_r;
  assign fsm_data_o = data_r;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      pump_pkg::e_idle:
        if (req_v_i)
          state_n = pump_pkg::e_issue;
      pump_pkg::e_issue:
        state_n = pump_pkg::e_wait;
      // store data lands during this state
      pump_pkg::e_wait:
        state_n = pump_pkg::e_done;
      pump_pkg::e_done:
        if (fsm_ready_and_i)
          state_n = last_beat ? pump_pkg::e_idle : pump_pkg::e_issue;
      default:
        state_n = pump_pkg::e_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= pump_pkg::e_idle;
      beat_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (accept)
        beat_r <= '0;
      else if (beat_done && !last_beat)
        beat_r <= beat_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      type_r <= req_type_i;
      addr_r <= req_addr_i;
      size_r <= req_size_i;
    end
    if (state_r == pump_pkg::e_wait)
      data_r <= rd_data_i;
  end

endmodule

`default_nettype wire

/* design/block_store.sv */
// *******************************************************************
// block store
// word memory loaded by index, read back through a registered port
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "stream_defs.svh"

module block_store
(
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire                     load_v_i,
  input  wire msg_pkg::word_idx_t load_idx_i,
  input  wire msg_pkg::data_t     load_data_i,
  input  wire                     rd_v_i,
  input  wire msg_pkg::word_idx_t rd_idx_i,
  output msg_pkg::data_t          rd_data_o
);

  msg_pkg::data_t mem [`STREAM_STORE_WORDS];

  // the load port has no handshake, every valid cycle writes one word
  always_ff @(posedge clk_i)
  begin
    if (load_v_i)
      mem[load_idx_i] <= load_data_i;
  end

  // the read port updates only on a strobe, so the FSM can sample it
  // any time after the read without the word changing underneath it
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rd_data_o <= '0;
    else if (rd_v_i)
      rd_data_o <= mem[rd_idx_i];
  end

endmodule

`default_nettype wire

/* design/mem_stream_top.sv */
// *******************************************************************
// memory stream engine top
// block store, read FSM and stream pump joined into one engine
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

module mem_stream_top
(
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire                     load_v_i,
  input  wire msg_pkg::word_idx_t load_idx_i,
  input  wire msg_pkg::data_t     load_data_i,
  input  wire                     req_v_i,
  input  wire msg_pkg::msg_type_e req_type_i,
  input  wire msg_pkg::addr_t     req_addr_i,
  input  wire msg_pkg::size_t     req_size_i,
  output logic                    req_ready_o,
  output logic                    msg_v_o,
  output msg_pkg::msg_type_e      msg_type_o,
  output msg_pkg::addr_t          msg_addr_o,
  output msg_pkg::size_t          msg_size_o,
  output msg_pkg::data_t          msg_data_o,
  output logic                    msg_last_o,
  input  wire                     msg_ready_and_i
);

  // store read port
  logic rd_v;
  msg_pkg::word_idx_t rd_idx;
  msg_pkg::data_t rd_data;

  // producer side from the FSM into the pump
  logic fsm_v, fsm_ready_and;
  msg_pkg::msg_type_e fsm_type;
  msg_pkg::addr_t fsm_addr;
  msg_pkg::size_t fsm_size;
  msg_pkg::data_t fsm_data;

  block_store store
  (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .load_v_i(load_v_i),
    .load_idx_i(load_idx_i),
    .load_data_i(load_data_i),
    .rd_v_i(rd_v),
    .rd_idx_i(rd_idx),
    .rd_data_o(rd_data)
  );

  block_read_fsm fsm
  (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .req_v_i(req_v_i),
    .req_type_i(req_type_i),
    .req_addr_i(req_addr_i),
    .req_size_i(req_size_i),
    .req_ready_o(req_ready_o),
    .rd_v_o(rd_v),
    .rd_idx_o(rd_idx),
    .rd_data_i(rd_data),
    .fsm_v_o(fsm_v),
    .fsm_type_o(fsm_type),
    .fsm_addr_o(fsm_addr),
    .fsm_size_o(fsm_size),
    .fsm_data_o(fsm_data),
    .fsm_ready_and_i(fsm_ready_and)
  );

  stream_pump_out pump
  (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .fsm_v_i(fsm_v),
    .fsm_type_i(fsm_type),
    .fsm_addr_i(fsm_addr),
    .fsm_size_i(fsm_size),
    .fsm_data_i(fsm_data),
    .fsm_ready_and_o(fsm_ready_and),
    .msg_v_o(msg_v_o),
    .msg_type_o(msg_type_o),
    .msg_addr_o(msg_addr_o),
    .msg_size_o(msg_size_o),
    .msg_data_o(msg_data_o),
    .msg_last_o(msg_last_o),
    .msg_ready_and_i(msg_ready_and_i)
  );

endmodule

`default_nettype wire

/* design/msg_pkg.sv */
// *******************************************************************
// message types
// header and payload types seen at the requester and stream ports
// *******************************************************************
`default_nettype none

`include "stream_defs.svh"

package msg_pkg;

  // encoding order matters, the stream masks index bits by this value
  typedef enum logic [1:0]
  {
    e_rd_resp  = 2'd0,
    e_pf_resp  = 2'd1,
    e_wr_merge = 2'd2,
    e_ack_resp = 2'd3
  } msg_type_e;

  typedef logic [`STREAM_ADDR_W-1:0] addr_t;

  // log2 of the message length in bytes, legal values are 2, 3 and 4
  typedef logic [`STREAM_SIZE_W-1:0] size_t;

  typedef logic [`STREAM_DATA_W-1:0] data_t;

  // word index into the block store
  typedef logic [$clog2(`STREAM_STORE_WORDS)-1:0] word_idx_t;

endpackage

`default_nettype wire

/* design/pump_pkg.sv */
// *******************************************************************
// pump types
// read FSM state, beat counts and FIFO pointers used inside the engine
// *******************************************************************
`default_nettype none

`include "stream_defs.svh"

package pump_pkg;

  typedef enum logic [1:0]
  {
    e_idle,
    e_issue,
    e_wait,
    e_done
  } rd_state_e;

  typedef logic [`STREAM_CNT_W-1:0] cnt_t;

  typedef logic [$clog2(`STREAM_FIFO_ELS)-1:0] fifo_ptr_t;

  // offset of the last word from the first, which is num_words minus one
  // it doubles as the mask of the count bits that the size covers
  function automatic cnt_t last_offset(input msg_pkg::size_t size);
    cnt_t span;
    if (size <= msg_pkg::size_t'(`STREAM_OFFSET_W))
      span = '0;
    else
      span = cnt_t'(((1 << size) >> `STREAM_OFFSET_W) - 1);
    return span;
  endfunction

  // only the bits under span step with wrap, the rest stay at first
  function automatic cnt_t wrap_cnt(input cnt_t first, input cnt_t cnt, input cnt_t span);
    return (first & ~span) | (cnt & span);
  endfunction

endpackage

`default_nettype wire

/* design/stream_defs.svh */
// *******************************************************************
// stream engine definitions
// widths, block geometry, stream masks and buffer depth
// *******************************************************************
`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

`define STREAM_ADDR_W 16
`define STREAM_DATA_W 32
`define STREAM_BLOCK_W 128
// number of stream words that make up one block
`define STREAM_WORDS (`STREAM_BLOCK_W / `STREAM_DATA_W)
`define STREAM_CNT_W 2
`define STREAM_OFFSET_W 2
`define STREAM_SIZE_W 3
`define STREAM_STORE_WORDS 64

// bit n is set when message type n streams several beats on the output side
// rd_resp is bit 0 and pf_resp is bit 1
`define STREAM_MSG_MASK 4'b0011
// bit n is set when message type n streams several beats on the producer side
// rd_resp is bit 0 and wr_merge is bit 2
`define STREAM_FSM_MASK 4'b0101

`define STREAM_FIFO_ELS 2

`endif

/* design/stream_fifo.sv */
// *******************************************************************
// stream FIFO
// buffers header and data beats between the read FSM and the pump
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "stream_defs.svh"

module stream_fifo
#(
  parameter int els_p = `STREAM_FIFO_ELS
)
(
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire                     in_v_i,
  input  wire msg_pkg::msg_type_e in_type_i,
  input  wire msg_pkg::addr_t     in_addr_i,
  input  wire msg_pkg::size_t     in_size_i,
  input  wire msg_pkg::data_t     in_data_i,
  output logic                    in_ready_and_o,
  output logic                    out_v_o,
  output msg_pkg::msg_type_e      out_type_o,
  output msg_pkg::addr_t          out_addr_o,
  output msg_pkg::size_t          out_size_o,
  output msg_pkg::data_t          out_data_o,
  input  wire                     out_ready_and_i
);

  msg_pkg::msg_type_e type_mem [els_p];
  msg_pkg::addr_t addr_mem [els_p];
  msg_pkg::size_t size_mem [els_p];
  msg_pkg::data_t data_mem [els_p];

  pump_pkg::fifo_ptr_t wptr_r, rptr_r;
  logic [$clog2(els_p+1)-1:0] count_r;
  logic push, pop;

  function automatic pump_pkg::fifo_ptr_t next_ptr(input pump_pkg::fifo_ptr_t ptr);
    return (ptr == pump_pkg::fifo_ptr_t'(els_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // no bypass, an entry is visible only after it sits in the array
  assign in_ready_and_o = (count_r != els_p);
  assign out_v_o = (count_r != '0);
  assign push = in_v_i & in_ready_and_o;
  assign pop = out_v_o & out_ready_and_i;

  assign out_type_o = type_mem[rptr_r];
  assign out_addr_o = addr_mem[rptr_r];
  assign out_size_o = size_mem[rptr_r];
  assign out_data_o = data_mem[rptr_r];

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      type_mem[wptr_r] <= in_type_i;
      addr_mem[wptr_r] <= in_addr_i;
      size_mem[wptr_r] <= in_size_i;
      data_mem[wptr_r] <= in_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wptr_r <= '0;
      rptr_r <= '0;
      count_r <= '0;
    end
    else
    begin
      if (push)
        wptr_r <= next_ptr(wptr_r);
      if (pop)
        rptr_r <= next_ptr(rptr_r);
      // a push and a pop in the same cycle leave the count alone
      if (push && !pop)
        count_r <= count_r + 1'b1;
      else if (pop && !push)
        count_r <= count_r - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* design/stream_pump_out.sv */
// *******************************************************************
// stream pump output side
// turns producer beats into stream beats in N:N, 1:N or N:1 form
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "stream_defs.svh"

module stream_pump_out
(
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire                     fsm_v_i,
  input  wire msg_pkg::msg_type_e fsm_type_i,
  input  wire msg_pkg::addr_t     fsm_addr_i,
  input  wire msg_pkg::size_t     fsm_size_i,
  input  wire msg_pkg::data_t     fsm_data_i,
  output logic                    fsm_ready_and_o,
  output logic                    msg_v_o,
  output msg_pkg::msg_type_e      msg_type_o,
  output msg_pkg::addr_t          msg_addr_o,
  output msg_pkg::size_t          msg_size_o,
  output msg_pkg::data_t          msg_data_o,
  output logic                    msg_last_o,
  input  wire                     msg_ready_and_i
);

  localparam logic [3:0] msg_mask_lp = `STREAM_MSG_MASK;
  localparam logic [3:0] fsm_mask_lp = `STREAM_FSM_MASK;
  localparam int hi_lp = `STREAM_OFFSET_W + `STREAM_CNT_W;

  msg_pkg::msg_type_e head_type;
  msg_pkg::addr_t head_addr;
  msg_pkg::size_t head_size;
  msg_pkg::data_t head_data;
  logic head_v, head_ready_and;

  pump_pkg::cnt_t first_cnt, last_cnt, span, current_cnt, cnt_lo, cnt_val, wrap;
  logic is_fsm_stream, is_msg_stream, any_stream_new, is_last_cnt;
  logic streaming_r, cnt_up, cnt_set, cnt_en, done;

  stream_fifo #(.els_p(`STREAM_FIFO_ELS)) fifo
  (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .in_v_i(fsm_v_i),
    .in_type_i(fsm_type_i),
    .in_addr_i(fsm_addr_i),
    .in_size_i(fsm_size_i),
    .in_data_i(fsm_data_i),
    .in_ready_and_o(fsm_ready_and_o),
    .out_v_o(head_v),
    .out_type_o(head_type),
    .out_addr_o(head_addr),
    .out_size_o(head_size),
    .out_data_o(head_data),
    .out_ready_and_i(head_ready_and)
  );

  beat_counter counter
  (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .set_i(cnt_set),
    .en_i(cnt_en),
    .val_i(cnt_val),
    .count_o(current_cnt)
  );

  // a single word request streams on neither side
  assign first_cnt = head_addr[`STREAM_OFFSET_W +: `STREAM_CNT_W];
  assign span = pump_pkg::last_offset(head_size);
  assign last_cnt = first_cnt + span;
  assign is_fsm_stream = fsm_mask_lp[head_type] & (span != '0);
  assign is_msg_stream = msg_mask_lp[head_type] & (span != '0);

  // the first beat of a message and every single beat message count from
  // the critical word, since the counter still holds zero from the previous message
  assign any_stream_new = (is_fsm_stream | is_msg_stream) & ~streaming_r;
  assign cnt_lo = (any_stream_new | ~(is_fsm_stream | is_msg_stream)) ? first_cnt
                                                                       : current_cnt;
  assign is_last_cnt = (cnt_lo == last_cnt) | ~(is_fsm_stream | is_msg_stream);
  assign wrap = pump_pkg::wrap_cnt(first_cnt, cnt_lo, span);

  assign done = head_ready_and & head_v & is_last_cnt;
  assign cnt_set = (any_stream_new & cnt_up) | done;
  assign cnt_en = cnt_up | done;
  assign cnt_val = done ? '0 : first_cnt + pump_pkg::cnt_t'(cnt_up);

  // clear wins over set, so a message ends with the flag low
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      streaming_r <= 1'b0;
    else if (done)
      streaming_r <= 1'b0;
    else if (cnt_up)
      streaming_r <= 1'b1;
  end

  assign msg_type_o = head_type;
  assign msg_size_o = head_size;
  assign msg_data_o = head_data;
  assign msg_last_o = is_last_cnt & msg_v_o;

  always_comb
  begin
    if (is_msg_stream && !is_fsm_stream)
    begin
      // 1:N, the single head word repeats and is popped with the last beat
      msg_v_o = head_v;
      head_ready_and = msg_ready_and_i & is_last_cnt;
      cnt_up = msg_v_o & msg_ready_and_i & ~is_last_cnt;
      msg_addr_o = {head_addr[`STREAM_ADDR_W-1:hi_lp], wrap,
                    head_addr[`STREAM_OFFSET_W-1:0]};
    end
    else if (is_fsm_stream && !is_msg_stream)
    begin
      // N:1, early words are dropped and the last one goes out
      // at the critical address
      msg_v_o = head_v & is_last_cnt;
      head_ready_and = ~is_last_cnt | msg_ready_and_i;
      cnt_up = head_ready_and & head_v & ~is_last_cnt;
      msg_addr_o = head_addr;
    end
    else
    begin
      // N:N, also covers every single beat message
      msg_v_o = head_v;
      head_ready_and = msg_ready_and_i;
      cnt_up = head_ready_and & head_v & ~is_last_cnt;
      msg_addr_o = {head_addr[`STREAM_ADDR_W-1:hi_lp], wrap,
                    head_addr[`STREAM_OFFSET_W-1:0]};
    end
  end

endmodule

`default_nettype wire

/* dv/stream_checker.sv */
// *******************************************************************
// stream checker
// models the block store and compares every stream beat it sees
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "stream_defs.svh"

module stream_checker
(
  input  wire                     clk_i,
  input  wire                     rst_n_i,
  input  wire                     load_v_i,
  input  wire msg_pkg::word_idx_t load_idx_i,
  input  wire msg_pkg::data_t     load_data_i,
  input  wire                     req_v_i,
  input  wire msg_pkg::msg_type_e req_type_i,
  input  wire msg_pkg::addr_t     req_addr_i,
  input  wire msg_pkg::size_t     req_size_i,
  input  wire                     req_ready_i,
  input  wire                     msg_v_i,
  input  wire msg_pkg::msg_type_e msg_type_i,
  input  wire msg_pkg::addr_t     msg_addr_i,
  input  wire msg_pkg::size_t     msg_size_i,
  input  wire msg_pkg::data_t     msg_data_i,
  input  wire                     msg_last_i,
  input  wire                     msg_ready_and_i,
  output int                      pass_cnt_o,
  output int                      fail_cnt_o,
  output int                      done_cnt_o
);

  localparam int word_lo_lp = `STREAM_OFFSET_W;
  localparam int blk_lo_lp = `STREAM_OFFSET_W + `STREAM_CNT_W;
  localparam int up_w_lp = $bits(msg_pkg::word_idx_t) - `STREAM_CNT_W;
  localparam int word_bytes_lp = `STREAM_DATA_W / 8;

  // copy of the store contents, kept up to date from the load port
  msg_pkg::data_t store_model [`STREAM_STORE_WORDS];

  // beats still owed by the DUT for the open request, oldest first
  msg_pkg::addr_t exp_addr_q [$];
  msg_pkg::data_t exp_data_q [$];
  logic exp_last_q [$];
  msg_pkg::msg_type_e exp_type;
  msg_pkg::size_t exp_size;

  string pending_name = "unnamed";
  string cur_name = "unnamed";
  int beat_errs = 0;
  int beats = 0;
  int passes = 0;
  int fails = 0;
  int dones = 0;

  // the testbench names the next request before it drives it
  task automatic name_next_request(input string name);
    pending_name = name;
  endtask

  function automatic int words_of(input msg_pkg::size_t size);
    int bytes;
    bytes = 1 << size;
    return (bytes > word_bytes_lp) ? bytes / word_bytes_lp : 1;
  endfunction

  // low index bits of word k, only the bits under mask step and wrap
  function automatic logic [1:0] word_low(input logic [1:0] first, input logic [1:0] mask,
                                          input int k);
    logic [1:0] step;
    step = first + k[1:0];
    return (first & ~mask) | (step & mask);
  endfunction

  function automatic msg_pkg::addr_t beat_addr(input msg_pkg::addr_t addr,
                                               input logic [1:0] low);
    return {addr[`STREAM_ADDR_W-1:blk_lo_lp], low, addr[word_lo_lp-1:0]};
  endfunction

  // upper store index bits come from the address above the block offset
  function automatic msg_pkg::data_t word_at(input msg_pkg::addr_t addr,
                                             input logic [1:0] low);
    msg_pkg::word_idx_t idx;
    idx = {addr[blk_lo_lp +: up_w_lp], low};
    return store_model[idx];
  endfunction

  task automatic push_beat(input msg_pkg::addr_t addr, input msg_pkg::data_t data,
                           input logic last);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
    exp_last_q.push_back(last);
  endtask

  // expected beats of one request, built from the conversion mode rules
  task automatic expect_beats(input msg_pkg::msg_type_e t, input msg_pkg::addr_t a,
                              input msg_pkg::size_t s);
    int n;
    int k;
    logic [1:0] first;
    logic [1:0] mask;
    logic [1:0] low;
    n = words_of(s);
    first = a[word_lo_lp +: 2];
    mask = 2'(n - 1);
    if (n == 1 || t == msg_pkg::e_ack_resp)
      push_beat(a, word_at(a, first), 1'b1);
    else if (t == msg_pkg::e_rd_resp)
    begin
      // one beat per word, each with its own wrapped address
      for (k = 0; k < n; k++)
      begin
        low = word_low(first, mask, k);
        push_beat(beat_addr(a, low), word_at(a, low), k == n - 1);
      end
    end
    else if (t == msg_pkg::e_pf_resp)
    begin
      // the critical word repeats at every wrapped address
      for (k = 0; k < n; k++)
      begin
        low = word_low(first, mask, k);
        push_beat(beat_addr(a, low), word_at(a, first), k == n - 1);
      end
    end
    else
    begin
      // write merge keeps the request address and carries the last word read
      low = word_low(first, mask, n - 1);
      push_beat(a, word_at(a, low), 1'b1);
    end
  endtask

  task automatic open_request();
    if (exp_addr_q.size() != 0)
    begin
      $display("request %s was accepted while %0d beats of %s were still missing",
               pending_name, exp_addr_q.size(), cur_name);
      fails++;
      exp_addr_q.delete();
      exp_data_q.delete();
      exp_last_q.delete();
    end
    cur_name = pending_name;
    exp_type = req_type_i;
    exp_size = req_size_i;
    beat_errs = 0;
    beats = 0;
    expect_beats(req_type_i, req_addr_i, req_size_i);
  endtask

  task automatic compare_field(input string field, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("** Error %s beat %0d %s: expected %h actual %h",
               cur_name, beats, field, exp_v, act_v);
      beat_errs++;
    end
  endtask

  task automatic close_request();
    if (beat_errs == 0)
    begin
      $display("PASS %s, %0d beats", cur_name, beats);
      passes++;
    end
    else
    begin
      $display("FAIL %s, %0d mismatches over %0d beats", cur_name, beat_errs, beats);
      fails++;
    end
    dones++;
  endtask

  task automatic check_beat();
    msg_pkg::addr_t a;
    msg_pkg::data_t d;
    logic l;
    if (exp_addr_q.size() == 0)
    begin
      $display("stray beat at address %h arrived after %s had finished",
               msg_addr_i, cur_name);
      fails++;
    end
    else
    begin
      a = exp_addr_q.pop_front();
      d = exp_data_q.pop_front();
      l = exp_last_q.pop_front();
      compare_field("address", 32'(a), 32'(msg_addr_i));
      compare_field("data", d, msg_data_i);
      compare_field("type", 32'(exp_type), 32'(msg_type_i));
      compare_field("size", 32'(exp_size), 32'(msg_size_i));
      compare_field("last", 32'(l), 32'(msg_last_i));
      beats++;
      if (l)
        close_request();
    end
  endtask

  // a beat transfers on the edge where valid and ready are both high
  always @(posedge clk_i)
  begin
    if (load_v_i)
      store_model[load_idx_i] = load_data_i;
    if (rst_n_i && req_v_i && req_ready_i)
      open_request();
    if (rst_n_i && msg_v_i && msg_ready_and_i)
      check_beat();
    pass_cnt_o <= passes;
    fail_cnt_o <= fails;
    done_cnt_o <= dones;
  end

endmodule

`default_nettype wire

/* dv/tb_top.sv */
// *******************************************************************
// stream engine testbench
// loads the store, runs a table of requests and checks the stream
// *******************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "stream_defs.svh"

module tb_top;

  localparam int clk_period_lp = 8;
  localparam int reset_cycles_lp = 3;
  localparam int cycles_per_test_lp = 200;

  logic clk = 1'b0;
  logic rst_n;
  logic load_v;
  msg_pkg::word_idx_t load_idx;
  msg_pkg::data_t load_data;
  logic req_v;
  msg_pkg::msg_type_e req_type;
  msg_pkg::addr_t req_addr;
  msg_pkg::size_t req_size;
  logic req_ready;
  logic msg_v;
  msg_pkg::msg_type_e msg_type;
  msg_pkg::addr_t msg_addr;
  msg_pkg::size_t msg_size;
  msg_pkg::data_t msg_data;
  logic msg_last;
  logic msg_ready;

  // request table, one entry per index across the queues
  string name_q [$];
  msg_pkg::msg_type_e type_q [$];
  msg_pkg::addr_t addr_q [$];
  msg_pkg::size_t size_q [$];
  bit bp_q [$];

  integer seed;
  logic bp_on;
  logic table_ready = 1'b0;
  int cur_test;
  int local_pass;
  int local_fail;
  int pass_cnt;
  int fail_cnt;
  int done_cnt;

  always #(clk_period_lp / 2) clk = ~clk;

  mem_stream_top dut
  (
    .clk_i(clk),
    .rst_n_i(rst_n),
    .load_v_i(load_v),
    .load_idx_i(load_idx),
    .load_data_i(load_data),
    .req_v_i(req_v),
    .req_type_i(req_type),
    .req_addr_i(req_addr),
    .req_size_i(req_size),
    .req_ready_o(req_ready),
    .msg_v_o(msg_v),
    .msg_type_o(msg_type),
    .msg_addr_o(msg_addr),
    .msg_size_o(msg_size),
    .msg_data_o(msg_data),
    .msg_last_o(msg_last),
    .msg_ready_and_i(msg_ready)
  );

  stream_checker chk
  (
    .clk_i(clk),
    .rst_n_i(rst_n),
    .load_v_i(load_v),
    .load_idx_i(load_idx),
    .load_data_i(load_data),
    .req_v_i(req_v),
    .req_type_i(req_type),
    .req_addr_i(req_addr),
    .req_size_i(req_size),
    .req_ready_i(req_ready),
    .msg_v_i(msg_v),
    .msg_type_i(msg_type),
    .msg_addr_i(msg_addr),
    .msg_size_i(msg_size),
    .msg_data_i(msg_data),
    .msg_last_i(msg_last),
    .msg_ready_and_i(msg_ready),
    .pass_cnt_o(pass_cnt),
    .fail_cnt_o(fail_cnt),
    .done_cnt_o(done_cnt)
  );

  // ready toggles at random while back-pressure is on, else stays high
  always @(negedge clk)
  begin : drive_ready
    logic [31:0] rnd;
    if (bp_on)
    begin
      rnd = $random(seed);
      msg_ready = rnd[0];
    end
    else
      msg_ready = 1'b1;
  end

  task automatic add_request(input string name, input msg_pkg::msg_type_e t,
                             input msg_pkg::addr_t a, input msg_pkg::size_t s, input bit bp);
    name_q.push_back(name);
    type_q.push_back(t);
    addr_q.push_back(a);
    size_q.push_back(s);
    bp_q.push_back(bp);
  endtask

  // sizes are log2 bytes, so 4 is a whole block and 2 a single word
  task automatic build_table();
    add_request("rd_full_mid", msg_pkg::e_rd_resp, 16'h0128, 3'd4, 1'b0);
    add_request("rd_size8_wrap", msg_pkg::e_rd_resp, 16'h034c, 3'd3, 1'b0);
    add_request("pf_full", msg_pkg::e_pf_resp, 16'h0254, 3'd4, 1'b0);
    add_request("wr_merge_full", msg_pkg::e_wr_merge, 16'h00e8, 3'd4, 1'b0);
    add_request("wr_merge_size8", msg_pkg::e_wr_merge, 16'h0134, 3'd3, 1'b0);
    add_request("pf_size8", msg_pkg::e_pf_resp, 16'h01c8, 3'd3, 1'b0);
    add_request("ack_full", msg_pkg::e_ack_resp, 16'h004c, 3'd4, 1'b0);
    add_request("ack_size8", msg_pkg::e_ack_resp, 16'h01b5, 3'd3, 1'b0);
    add_request("ack_size4", msg_pkg::e_ack_resp, 16'h00ae, 3'd2, 1'b0);
    add_request("rd_size4", msg_pkg::e_rd_resp, 16'h0077, 3'd2, 1'b0);
    add_request("pf_size4", msg_pkg::e_pf_resp, 16'h00fb, 3'd2, 1'b0);
    add_request("wr_merge_size4", msg_pkg::e_wr_merge, 16'h0024, 3'd2, 1'b0);
    // same modes again with the stream stalled at random
    add_request("bp_rd_full", msg_pkg::e_rd_resp, 16'h03fc, 3'd4, 1'b1);
    add_request("bp_rd_size8", msg_pkg::e_rd_resp, 16'h0016, 3'd3, 1'b1);
    add_request("bp_pf_full", msg_pkg::e_pf_resp, 16'h0128, 3'd4, 1'b1);
    add_request("bp_wr_merge_full", msg_pkg::e_wr_merge, 16'h02e4, 3'd4, 1'b1);
  endtask

  task automatic check_reset_state();
    int errs;
    errs = 0;
    if (msg_v !== 1'b0)
    begin
      $display("** Error reset_state msg_v_o: expected 0 actual %b", msg_v);
      errs++;
    end
    if (req_ready !== 1'b1)
    begin
      $display("** Error reset_state req_ready_o: expected 1 actual %b", req_ready);
      errs++;
    end
    if (errs == 0)
    begin
      $display("PASS reset_state");
      local_pass++;
    end
    else
      local_fail++;
  endtask

  // one word per cycle, the checker picks each up from the load port
  task automatic load_store();
    int i;
    for (i = 0; i < `STREAM_STORE_WORDS; i++)
    begin
      @(negedge clk);
      load_v = 1'b1;
      load_idx = msg_pkg::word_idx_t'(i);
      load_data = $random(seed);
    end
    @(negedge clk);
    load_v = 1'b0;
  endtask

  task automatic run_request(input int i);
    // back-pressure and the name change between edges
    @(posedge clk);
    cur_test = i;
    bp_on = bp_q[i];
    chk.name_next_request(name_q[i]);
    @(negedge clk);
    req_v = 1'b1;
    req_type = type_q[i];
    req_addr = addr_q[i];
    req_size = size_q[i];
    do
      @(posedge clk);
    while (!req_ready);
    @(negedge clk);
    req_v = 1'b0;
    while (done_cnt < i + 1)
      @(posedge clk);
  endtask

  initial
  begin : main
    int i;
    int passes;
    int fails;
    rst_n = 1'b0;
    load_v = 1'b0;
    load_idx = '0;
    load_data = '0;
    req_v = 1'b0;
    req_type = msg_pkg::e_rd_resp;
    req_addr = '0;
    req_size = '0;
    msg_ready = 1'b1;
    bp_on = 1'b0;
    seed = 32'hf4b;
    cur_test = -1;
    local_pass = 0;
    local_fail = 0;
    build_table();
    table_ready = 1'b1;
    repeat (reset_cycles_lp) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    load_store();
    for (i = 0; i < name_q.size(); i++)
      run_request(i);
    @(posedge clk);
    bp_on = 1'b0;
    // idle a while so that any stray beat still gets caught
    repeat (20) @(posedge clk);
    passes = pass_cnt + local_pass;
    fails = fail_cnt + local_fail;
    $display("tests passed %0d, failed %0d", passes, fails);
    if (fails == 0 && done_cnt == name_q.size())
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // limit covers reset, store load and a fixed budget per request
  initial
  begin : watchdog
    int limit;
    wait (table_ready);
    limit = name_q.size() * cycles_per_test_lp + reset_cycles_lp + `STREAM_STORE_WORDS + 40;
    repeat (limit) @(posedge clk);
    if (cur_test < 0)
      $display("watchdog expired before the first request was sent");
    else
      $display("watchdog expired, request %s never finished", name_q[cur_test]);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
